/* test/qla_tests.txt */
// columns: op addr/axis data/steps expected (hex); op 1 write, 2 read-check, 3 feedback,
// 4 encoder steps, 5 wait cycles, 6 pins {pwr_enable, amp_disable}, 0 end
6 0000 00000000 0000000F  // reset: power off, all amps disabled
2 0000 00000000 05000000  // status holds only the board id
1 0011 00001000 00000000  // axis 1 command, limit 0x2000
1 0021 00000200 00000000
1 0031 00000300 00000000
1 0041 00000400 00000000
2 0011 00000000 00001000
2 0041 00000000 00000400
3 0000 00000123 00000000  // axis 1 feedback
2 0010 00000000 00000123
2 0012 00000000 00000000  // unmapped offset
2 0060 00000000 00000000  // channel 6
2 1011 00000000 00000000  // space 1
1 0000 000C0505 00000000  // power on, enable axes 1 and 3
6 0000 00000000 0000001A
2 0000 00000000 05080500
1 0000 0008000F 00000000  // values without masks
6 0000 00000000 0000001A
3 0000 00002000 00000000  // exactly twice the command
5 0000 0000000A 00000000
6 0000 00000000 0000001A
3 0000 00002001 00000000  // one above the limit
5 0000 00000006 00000000
6 0000 00000000 0000001B
2 0000 00000000 05080501
3 0000 00000100 00000000  // lower feedback, then re-enable axis 1
1 0000 00000101 00000000
5 0000 00000002 00000000
6 0000 00000000 0000001A
2 0000 00000000 05080500
1 0013 00000100 00000000  // encoder 1 preload
2 0014 00000000 00000100
4 0000 0000000A 00000000  // 10 forward
2 0014 00000000 0000010A
4 0000 FFFFFFF4 00000000  // 12 backward
2 0014 00000000 000000FE
2 0013 00000000 00000100
0 0000 00000000 00000000

/* qla_core.f */
rtl/qla_pkg.sv
rtl/current_regs.sv
rtl/safety_check.sv
rtl/enc_counters.sv
rtl/board_regs.sv
rtl/reg_read_mux.sv
rtl/qla_core.sv
test/qla_core_assertions.sv
test/tb_qla_core.sv

/* Makefile */
SRCS := $(shell cat qla_core.f)

.PHONY: all run clean

all: obj_dir/Vtb_qla_core

obj_dir/Vtb_qla_core: qla_core.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module tb_qla_core -f qla_core.f

run: obj_dir/Vtb_qla_core test/qla_tests.txt
	./obj_dir/Vtb_qla_core > sim.log 2>&1; cat sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_qla_core.sv */
// qla_core testbench with clock, reset, file-driven bus and pin stimulus, checks, watchdog

`timescale 1ns/1ps

module tb_qla_core;

    import qla_pkg::*;

    localparam int MAX_LINES   = 64;    // room in the test memory
    localparam int LINE_CYCLES = 64;    // watchdog budget per test line

    // operation codes in the first column of the test file
    localparam logic [31:0] OP_END      = 32'd0;
    localparam logic [31:0] OP_WRITE    = 32'd1;
    localparam logic [31:0] OP_READ     = 32'd2;
    localparam logic [31:0] OP_FEEDBACK = 32'd3;
    localparam logic [31:0] OP_ENC      = 32'd4;
    localparam logic [31:0] OP_WAIT     = 32'd5;
    localparam logic [31:0] OP_PINS     = 32'd6;

    logic                sysclk;
    logic                rst;
    logic                reg_wen;
    reg_addr_t           reg_waddr;
    reg_data_t           reg_wdata;
    reg_addr_t           reg_raddr;
    reg_data_t           reg_rdata;
    cur_t                cur_fb [NUM_AXES];
    logic [NUM_AXES-1:0] enc_a;
    logic [NUM_AXES-1:0] enc_b;
    board_id_t           board_id;
    logic [NUM_AXES-1:0] amp_disable;
    logic                pwr_enable;

    logic [31:0] tests [4*MAX_LINES];   // op, addr, data, expected per line
    int          enc_phase [NUM_AXES];  // position in the gray cycle
    int          n_lines = 0;           // stays 0 until the file is scanned
    int          errors  = 0;
    int          checks  = 0;

    qla_core #(
        .SAFETY_COUNT    (4),
        .ENC_SYNC_STAGES (2)
    ) i_qla_core (
        .sysclk      (sysclk),
        .rst         (rst),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .cur_fb      (cur_fb),
        .enc_a       (enc_a),
        .enc_b       (enc_b),
        .board_id    (board_id),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;    // 4 ns period
    end

    // ------------------------------------------------------------------------
    // bus and pin helpers, all entered on a falling edge
    function automatic logic [1:0] gray_state(input int phase);
        case (phase)
            0:       return 2'b00;      // {a, b}
            1:       return 2'b10;      // a rises first going forward
            2:       return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        @(negedge sysclk);              // single strobe
        reg_wen   = 1'b0;
    endtask

    task automatic read_check(input reg_addr_t addr, input reg_data_t expv);
        reg_raddr = addr;
        @(posedge sysclk);
        @(negedge sysclk);              // data one clock after the address
        checks++;
        if (reg_rdata !== expv) begin
            errors++;
            $display("FAIL %0t: read %h returned %h, expected %h", $time, addr, reg_rdata, expv);
        end
    endtask

    task automatic pins_check(input logic [4:0] expv);
        checks++;
        if ({pwr_enable, amp_disable} !== expv) begin
            errors++;
            $display("FAIL %0t: pwr_enable/amp_disable are %b, expected %b", $time,
                     {pwr_enable, amp_disable}, expv);
        end
    endtask

    task automatic step_encoder(input int axis, input int steps);
        int         n;
        int         dir;
        logic [1:0] ab;
        n   = (steps < 0) ? -steps : steps;
        dir = (steps < 0) ? -1 : 1;
        repeat (n) begin
            enc_phase[axis] = (enc_phase[axis] + dir) & 3;
            ab              = gray_state(enc_phase[axis]);
            enc_a[axis]     = ab[1];
            enc_b[axis]     = ab[0];
            repeat (4) @(negedge sysclk);   // one state per 4 cycles
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    initial begin
        int          cnt;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expv;
        rst       = 1'b1;
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        enc_a     = '0;
        enc_b     = '0;
        board_id  = 4'h5;               // arbitrary switch setting
        for (int i = 0; i < NUM_AXES; i++) begin
            cur_fb[i]    = '0;
            enc_phase[i] = 0;
        end
        $readmemh("test/qla_tests.txt", tests);
        cnt = 0;
        while (cnt < MAX_LINES && tests[4*cnt] != OP_END)
            cnt++;
        n_lines = cnt + 1;              // end marker counts too, starts the watchdog

        repeat (5) @(posedge sysclk);   // five reset clocks
        @(negedge sysclk);
        rst = 1'b0;

        for (int t = 0; t < n_lines - 1; t++) begin
            op   = tests[4*t];
            addr = tests[4*t+1];
            data = tests[4*t+2];
            expv = tests[4*t+3];
            case (op)
                OP_WRITE:    bus_write(addr[15:0], data);
                OP_READ:     read_check(addr[15:0], expv);
                OP_FEEDBACK: begin
                    cur_fb[addr[1:0]] = data[15:0];     // addr column is the axis
                    @(negedge sysclk);
                end
                OP_ENC:      step_encoder(int'(addr[1:0]), $signed(data));
                OP_WAIT:     repeat (data) @(negedge sysclk);
                OP_PINS:     pins_check(expv[4:0]);
                default: begin
                    errors++;
                    $display("test line %0d has an unknown operation code %0d", t, op);
                end
            endcase
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog sized from the number of test lines
    initial begin
        wait (n_lines != 0);
        repeat (n_lines * LINE_CYCLES) @(posedge sysclk);
        $display("timeout: the tests did not finish within %0d clock cycles",
                 n_lines * LINE_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* test/qla_core_assertions.sv */
// bound concurrent assertions on amp disable, safety clear pulses and unmapped reads

`timescale 1ns/1ps

module qla_core_assertions (
    input logic                         sysclk,
    input logic                         rst,
    input logic [qla_pkg::NUM_AXES-1:0] safety_disable,
    input logic [qla_pkg::NUM_AXES-1:0] safety_clear,
    input logic [qla_pkg::NUM_AXES-1:0] amp_disable,
    input qla_pkg::reg_addr_t           reg_raddr,
    input qla_pkg::reg_data_t           reg_rdata
);

    import qla_pkg::*;

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        // a tripped axis has its amp off on the next clock
        a_amp_follows_trip: assert property (@(posedge sysclk) disable iff (rst)
            safety_disable[i] |=> amp_disable[i])
            else $error("amp_disable[%0d] not set after safety trip", i);

        // clear is a single-cycle pulse
        a_clear_pulse: assert property (@(posedge sysclk) disable iff (rst)
            safety_clear[i] |=> !safety_clear[i])
            else $error("safety_clear[%0d] high for two cycles", i);
    end

    a_unmapped_space: assert property (@(posedge sysclk) disable iff (rst)
        (addr_space(reg_raddr) != ADDR_MAIN) |=> (reg_rdata == '0))
        else $error("read outside the main space returned nonzero data");

endmodule

bind qla_core qla_core_assertions i_qla_core_assertions (
    .sysclk         (sysclk),
    .rst            (rst),
    .safety_disable (safety_disable),
    .safety_clear   (safety_clear),
    .amp_disable    (amp_disable),
    .reg_raddr      (reg_raddr),
    .reg_rdata      (reg_rdata)
);

/* rtl/qla_core.sv */
// top level tying the current, safety, encoder and board peers to the register bus

`timescale 1ns/1ps

module qla_core #(
    parameter int SAFETY_COUNT    = 4,      // over-limit cycles before trip
    parameter int ENC_SYNC_STAGES = 2       // encoder input synchronizer depth
) (
    input  logic                          sysclk,
    input  logic                          rst,
    // register bus from the host
    input  logic                          reg_wen,
    input  qla_pkg::reg_addr_t            reg_waddr,
    input  qla_pkg::reg_data_t            reg_wdata,
    input  qla_pkg::reg_addr_t            reg_raddr,
    output qla_pkg::reg_data_t            reg_rdata,
    // board i/o
    input  qla_pkg::cur_t                 cur_fb [qla_pkg::NUM_AXES],  // parallel adc words
    input  logic [qla_pkg::NUM_AXES-1:0]  enc_a,
    input  logic [qla_pkg::NUM_AXES-1:0]  enc_b,
    input  qla_pkg::board_id_t            board_id,
    output logic [qla_pkg::NUM_AXES-1:0]  amp_disable,
    output logic                          pwr_enable
);

    import qla_pkg::*;

    cur_t                cur_cmd [NUM_AXES];    // to dacs and safety
    logic [NUM_AXES-1:0] safety_disable;
    logic [NUM_AXES-1:0] safety_clear;
    reg_data_t           axis_rdata;
    reg_data_t           enc_rdata;
    reg_data_t           board_rdata;

    // ---------------------------------------------------------------------------
    // axis peers
    current_regs i_current_regs (
        .sysclk     (sysclk),
        .rst        (rst),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_raddr  (reg_raddr),
        .cur_fb     (cur_fb),
        .cur_cmd    (cur_cmd),
        .axis_rdata (axis_rdata)
    );

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_safety
        safety_check #(
            .SAFETY_COUNT (SAFETY_COUNT)
        ) i_safety_check (
            .sysclk (sysclk),
            .rst    (rst),
            .cur_in (cur_fb[i]),
            .cmd_in (cur_cmd[i]),
            .clear  (safety_clear[i]),
            .trip   (safety_disable[i])
        );
    end

    enc_counters #(
        .ENC_SYNC_STAGES (ENC_SYNC_STAGES)
    ) i_enc_counters (
        .sysclk    (sysclk),
        .rst       (rst),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_raddr (reg_raddr),
        .enc_rdata (enc_rdata)
    );

    // ---------------------------------------------------------------------------
    // channel 0 and read return
    board_regs i_board_regs (
        .sysclk         (sysclk),
        .rst            (rst),
        .reg_wen        (reg_wen),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .reg_raddr      (reg_raddr),
        .safety_disable (safety_disable),
        .board_id       (board_id),
        .safety_clear   (safety_clear),
        .amp_disable    (amp_disable),
        .pwr_enable     (pwr_enable),
        .board_rdata    (board_rdata)
    );

    reg_read_mux i_reg_read_mux (
        .sysclk      (sysclk),
        .rst         (rst),
        .reg_raddr   (reg_raddr),
        .board_rdata (board_rdata),
        .axis_rdata  (axis_rdata),
        .enc_rdata   (enc_rdata),
        .reg_rdata   (reg_rdata)
    );

endmodule

/* rtl/reg_read_mux.sv */
// read-return selector choosing which peer's registered word goes back to the host

`timescale 1ns/1ps

module reg_read_mux (
    input  logic               sysclk,
    input  logic               rst,
    input  qla_pkg::reg_addr_t reg_raddr,
    input  qla_pkg::reg_data_t board_rdata,
    input  qla_pkg::reg_data_t axis_rdata,
    input  qla_pkg::reg_data_t enc_rdata,
    output qla_pkg::reg_data_t reg_rdata
);

    import qla_pkg::*;

    reg_addr_t raddr_q;     // lines up with the peers' registered words

    always_ff @(posedge sysclk) begin
        if (rst)
            raddr_q <= '0;
        else
            raddr_q <= reg_raddr;
    end

    // ---------------------------------------------------------------------------
    // select, zero for anything outside the map
    always_comb begin
        reg_rdata = '0;
        if (addr_space(raddr_q) == ADDR_MAIN) begin
            if (addr_chan(raddr_q) == CHAN_BOARD) begin
                reg_rdata = board_rdata;
            end else if (addr_chan(raddr_q) <= addr_field_t'(NUM_AXES)) begin
                case (addr_off(raddr_q))
                    OFF_ADC_DATA, OFF_DAC_CTRL: reg_rdata = axis_rdata;
                    OFF_ENC_LOAD, OFF_ENC_DATA: reg_rdata = enc_rdata;
                    default: reg_rdata = '0;    // unmapped axis offset
                endcase
            end
        end
    end

endmodule

/* rtl/board_regs.sv */
// channel 0 status and control register, amplifier disable outputs, safety clear pulses

`timescale 1ns/1ps

module board_regs (
    input  logic                          sysclk,
    input  logic                          rst,
    input  logic                          reg_wen,
    input  qla_pkg::reg_addr_t            reg_waddr,
    input  qla_pkg::reg_data_t            reg_wdata,
    input  qla_pkg::reg_addr_t            reg_raddr,
    input  logic [qla_pkg::NUM_AXES-1:0]  safety_disable,
    input  qla_pkg::board_id_t            board_id,
    output logic [qla_pkg::NUM_AXES-1:0]  safety_clear,
    output logic [qla_pkg::NUM_AXES-1:0]  amp_disable,
    output logic                          pwr_enable,
    output qla_pkg::reg_data_t            board_rdata
);

    import qla_pkg::*;

    logic                status_wr;
    logic                pwr_en_nxt;
    logic [NUM_AXES-1:0] amp_en;
    logic [NUM_AXES-1:0] amp_en_nxt;
    logic [NUM_AXES-1:0] clear_req;
    reg_data_t           status_word;

    assign status_wr = reg_wen && (addr_space(reg_waddr) == ADDR_MAIN) &&
                       (addr_chan(reg_waddr) == CHAN_BOARD) &&
                       (addr_off(reg_waddr) == OFF_STATUS);

    // ---------------------------------------------------------------------------
    // masked writes change only bits with their mask set
    always_comb begin
        pwr_en_nxt = pwr_enable;
        amp_en_nxt = amp_en;
        clear_req  = '0;
        if (status_wr) begin
            if (reg_wdata[WR_PWR_MASK])
                pwr_en_nxt = reg_wdata[WR_PWR_VAL];
            for (int i = 0; i < NUM_AXES; i++) begin
                if (reg_wdata[WR_AMP_MASK_LO + i])
                    amp_en_nxt[i] = reg_wdata[WR_AMP_VAL_LO + i];
            end
            // enabling an axis clears its latch, powering up clears all
            clear_req = reg_wdata[WR_AMP_MASK_LO +: NUM_AXES] &
                        reg_wdata[WR_AMP_VAL_LO +: NUM_AXES];
            if (reg_wdata[WR_PWR_MASK] && reg_wdata[WR_PWR_VAL])
                clear_req = '1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            pwr_enable   <= 1'b0;
            amp_en       <= '0;
            amp_disable  <= '1;                        // amps off out of reset
            safety_clear <= '0;
        end else begin
            pwr_enable   <= pwr_en_nxt;
            amp_en       <= amp_en_nxt;
            amp_disable  <= ~(amp_en_nxt & {NUM_AXES{pwr_en_nxt}} & ~safety_disable);
            safety_clear <= clear_req;                 // one pulse per status write
        end
    end

    // status word in the read layout
    always_comb begin
        status_word = '0;
        status_word[ST_SAFETY_LO +: NUM_AXES]               = safety_disable;
        status_word[ST_AMP_EN_LO +: NUM_AXES]               = amp_en;
        status_word[ST_PWR_EN]                              = pwr_enable;
        status_word[ST_BOARD_ID_LO +: $bits(board_id_t)]    = board_id;
    end

    always_ff @(posedge sysclk) begin
        if (rst)
            board_rdata <= '0;
        else if (addr_off(reg_raddr) == OFF_STATUS)
            board_rdata <= status_word;
        else
            board_rdata <= '0;                        // other board offsets unmapped
    end

endmodule

/* rtl/enc_counters.sv */
// quadrature input synchronizers, decode and preloadable counters for four axes

`timescale 1ns/1ps

module enc_counters #(
    parameter int ENC_SYNC_STAGES = 2
) (
    input  logic                          sysclk,
    input  logic                          rst,
    input  logic [qla_pkg::NUM_AXES-1:0]  enc_a,
    input  logic [qla_pkg::NUM_AXES-1:0]  enc_b,
    input  logic                          reg_wen,
    input  qla_pkg::reg_addr_t            reg_waddr,
    input  qla_pkg::reg_data_t            reg_wdata,
    input  qla_pkg::reg_addr_t            reg_raddr,
    output qla_pkg::reg_data_t            enc_rdata
);

    import qla_pkg::*;

    logic [ENC_SYNC_STAGES-1:0] a_sync [NUM_AXES];
    logic [ENC_SYNC_STAGES-1:0] b_sync [NUM_AXES];
    logic [1:0]                 ab_cur [NUM_AXES];   // {a, b} after sync
    logic [1:0]                 ab_prev [NUM_AXES];
    logic [NUM_AXES-1:0]        step_up;
    logic [NUM_AXES-1:0]        step_dn;
    logic                       load_wr;
    enc_count_t                 count [NUM_AXES];
    enc_count_t                 preload [NUM_AXES];
    reg_data_t                  rdata_nxt;

    // ---------------------------------------------------------------------------
    // synchronizers and previous gray state
    always_ff @(posedge sysclk) begin
        for (int i = 0; i < NUM_AXES; i++) begin
            a_sync[i][0] <= enc_a[i];
            b_sync[i][0] <= enc_b[i];
            for (int s = 1; s < ENC_SYNC_STAGES; s++) begin
                a_sync[i][s] <= a_sync[i][s-1];
                b_sync[i][s] <= b_sync[i][s-1];
            end
            ab_prev[i] <= ab_cur[i];
        end
    end

    // up when a leads b in the gray sequence
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            ab_cur[i]  = {a_sync[i][ENC_SYNC_STAGES-1], b_sync[i][ENC_SYNC_STAGES-1]};
            step_up[i] = 1'b0;
            step_dn[i] = 1'b0;
            case ({ab_prev[i], ab_cur[i]})
                4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step_up[i] = 1'b1;
                4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: step_dn[i] = 1'b1;
                default: ;              // no change or both bits moved
            endcase
        end
    end

    // ---------------------------------------------------------------------------
    // counters and preload
    assign load_wr = reg_wen && (addr_space(reg_waddr) == ADDR_MAIN) &&
                     (addr_off(reg_waddr) == OFF_ENC_LOAD);

    always_ff @(posedge sysclk) begin
        for (int i = 0; i < NUM_AXES; i++) begin
            if (rst) begin
                count[i]   <= '0;
                preload[i] <= '0;
            end else if (load_wr && (addr_chan(reg_waddr) == addr_field_t'(i + 1))) begin
                preload[i] <= reg_wdata[$bits(enc_count_t)-1:0];
                count[i]   <= reg_wdata[$bits(enc_count_t)-1:0];  // wins over a step
            end else if (step_up[i]) begin
                count[i] <= count[i] + 1'b1;
            end else if (step_dn[i]) begin
                count[i] <= count[i] - 1'b1;
            end
        end
    end

    // zero-extended read word
    always_comb begin
        rdata_nxt = '0;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (addr_chan(reg_raddr) == addr_field_t'(i + 1)) begin
                if (addr_off(reg_raddr) == OFF_ENC_LOAD)
                    rdata_nxt = reg_data_t'(preload[i]);
                else if (addr_off(reg_raddr) == OFF_ENC_DATA)
                    rdata_nxt = reg_data_t'(count[i]);
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst)
            enc_rdata <= '0;
        else
            enc_rdata <= rdata_nxt;
    end

endmodule

/* rtl/safety_check.sv */
// overcurrent persistence counter and amplifier disable latch for one axis

`timescale 1ns/1ps

module safety_check #(
    parameter int SAFETY_COUNT = 4      // over-limit cycles before a trip, 2 or more
) (
    input  logic          sysclk,
    input  logic          rst,
    input  qla_pkg::cur_t cur_in,       // feedback
    input  qla_pkg::cur_t cmd_in,       // command
    input  logic          clear,        // one-cycle pulse from board regs
    output logic          trip
);

    localparam int CNT_W = $clog2(SAFETY_COUNT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SAFETY_COUNT - 1);

    logic [16:0]      limit;            // 2 * cmd, one extra bit
    logic             over_limit;
    logic [CNT_W-1:0] persist_cnt;      // consecutive over-limit cycles

    assign limit      = {cmd_in, 1'b0};
    assign over_limit = ({1'b0, cur_in} > limit);   // equal is still ok

    // ---------------------------------------------------------------------------
    // persistence and latch
    always_ff @(posedge sysclk) begin
        if (rst) begin
            persist_cnt <= '0;
            trip        <= 1'b0;
        end else if (clear) begin       // clear beats a trip in the same cycle
            persist_cnt <= '0;
            trip        <= 1'b0;
        end else if (over_limit) begin
            if (persist_cnt == CNT_LAST)
                trip <= 1'b1;           // count stays saturated
            else
                persist_cnt <= persist_cnt + CNT_W'(1);
        end else begin
            persist_cnt <= '0;          // must be consecutive
        end
    end

endmodule

/* rtl/current_regs.sv */
// per-axis current command registers, command and feedback readback

`timescale 1ns/1ps

module current_regs (
    input  logic               sysclk,
    input  logic               rst,
    input  logic               reg_wen,
    input  qla_pkg::reg_addr_t reg_waddr,
    input  qla_pkg::reg_data_t reg_wdata,
    input  qla_pkg::reg_addr_t reg_raddr,
    input  qla_pkg::cur_t      cur_fb [qla_pkg::NUM_AXES],
    output qla_pkg::cur_t      cur_cmd [qla_pkg::NUM_AXES],
    output qla_pkg::reg_data_t axis_rdata
);

    import qla_pkg::*;

    logic      dac_wr;      // write to some axis command
    reg_data_t rdata_nxt;

    assign dac_wr = reg_wen && (addr_space(reg_waddr) == ADDR_MAIN) &&
                    (addr_off(reg_waddr) == OFF_DAC_CTRL);

    // command registers, channel n drives axis n-1
    always_ff @(posedge sysclk) begin
        for (int i = 0; i < NUM_AXES; i++) begin
            if (rst)
                cur_cmd[i] <= '0;
            else if (dac_wr && (addr_chan(reg_waddr) == addr_field_t'(i + 1)))
                cur_cmd[i] <= reg_wdata[$bits(cur_t)-1:0];   // low half only
        end
    end

    // read word, low 16 bits
    always_comb begin
        rdata_nxt = '0;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (addr_chan(reg_raddr) == addr_field_t'(i + 1)) begin
                if (addr_off(reg_raddr) == OFF_ADC_DATA)
                    rdata_nxt = reg_data_t'(cur_fb[i]);
                else if (addr_off(reg_raddr) == OFF_DAC_CTRL)
                    rdata_nxt = reg_data_t'(cur_cmd[i]);
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst)
            axis_rdata <= '0;
        else
            axis_rdata <= rdata_nxt;    // one clock read latency
    end

endmodule

/* rtl/qla_pkg.sv */
// address map fields and offsets, width typedefs, status bit layout

package qla_pkg;

    // -------------------------------------------------------------------------
    // widths with a meaning
    typedef logic [15:0] reg_addr_t;    // space | .... | channel | offset
    typedef logic [31:0] reg_data_t;    // bus data word
    typedef logic [15:0] cur_t;         // unsigned current value
    typedef logic [23:0] enc_count_t;   // encoder count
    typedef logic [3:0]  board_id_t;    // rotary switch
    typedef logic [3:0]  addr_field_t;  // one nibble of the address

    localparam int NUM_AXES = 4;        // fixed by the register map

    // address map
    localparam addr_field_t ADDR_MAIN  = 4'h0;  // only mapped space
    localparam addr_field_t CHAN_BOARD = 4'h0;  // channel 0, axes are 1..4

    // axis offsets
    localparam addr_field_t OFF_ADC_DATA = 4'd0;  // feedback, ro
    localparam addr_field_t OFF_DAC_CTRL = 4'd1;  // command, rw
    localparam addr_field_t OFF_ENC_LOAD = 4'd3;  // preload, rw
    localparam addr_field_t OFF_ENC_DATA = 4'd4;  // count, ro

    // board offsets
    localparam addr_field_t OFF_STATUS = 4'd0;

    // -------------------------------------------------------------------------
    // status word, read layout
    localparam int ST_SAFETY_LO   = 0;   // safety disable per axis
    localparam int ST_AMP_EN_LO   = 8;   // amp enable per axis
    localparam int ST_PWR_EN      = 19;
    localparam int ST_BOARD_ID_LO = 24;

    // status word, write layout (value/mask pairs)
    localparam int WR_AMP_VAL_LO  = 0;
    localparam int WR_AMP_MASK_LO = 8;
    localparam int WR_PWR_MASK    = 18;
    localparam int WR_PWR_VAL     = 19;

    // field extraction
    function automatic addr_field_t addr_space(reg_addr_t addr);
        return addr[15:12];
    endfunction

    function automatic addr_field_t addr_chan(reg_addr_t addr);
        return addr[7:4];
    endfunction

    function automatic addr_field_t addr_off(reg_addr_t addr);
        return addr[3:0];
    endfunction

endpackage
